// ==== Makefile ====
# Verilator build and run for the APB UART

VERILATOR  ?= verilator
TOP        ?= tb_apb_uart
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= NO ERRORS

SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_apb_uart.sv ====
// Testbench for the APB UART
`timescale 1ns/1ns
`include "uart_defs.svh"

module tb_apb_uart;
    import uart_line_pkg::*;
    import uart_reg_pkg::*;

    localparam int N_BYTES    = 20;
    localparam int MAX_DIV    = 15;
    localparam int BIG_DIV    = 64;
    localparam int N_FULL     = `UART_FIFO_DEPTH + 2;
    localparam int FRAME_MAX  = 11 * MAX_DIV + 1;
    localparam int MAX_CYCLES = 2 * ((3 * N_BYTES + 1) * FRAME_MAX
                                     + N_FULL * (10 * BIG_DIV + 1)) + 5000;
    localparam int ST_EMPTY   = 0;             // Status bit positions
    localparam int ST_FULL    = 1;
    localparam int ST_PERR    = 2;
    localparam int ST_BUSY    = 3;

    logic        clk_i;
    logic        rstn_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        uart_tx;
    logic        uart_rx;
    logic        loopback;
    logic        inj_line;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    uart_byte_t  model_q[$];

    apb_uart apb_uart_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .apb_i    (apb_req),
        .apb_o    (apb_rsp),
        .uart_rx_i(uart_rx),
        .uart_tx_o(uart_tx)
    );

    assign uart_rx = loopback ? uart_tx : inj_line;

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation timed out");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic random_div(output uart_div_t div);
        logic [31:0] r;
        take_bits(4, r);
        div = uart_div_t'(4 + r % 12);               // Range 4 to 15
    endtask

    function automatic logic [31:0] ctrl_word(input logic odd, input logic even,
                                              input logic rx_en, input logic tx_en);
        ctrl_reg_t c;
        c = '0;
        c.parity_odd  = odd;
        c.parity_even = even;
        c.rx_rstn     = rx_en;
        c.tx_rstn     = tx_en;
        return c;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Check %s did not match", name);
        end
    endtask

    // No wait states and no error responses in the access phase
    task automatic check_apb_response();
        check_eq("apb_pready", 32'h1, 32'(apb_rsp.pready));
        check_eq("apb_pslverr", 32'h0, 32'(apb_rsp.pslverr));
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        @(negedge clk_i);
        check_apb_response();
        @(posedge clk_i);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk_i);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        @(negedge clk_i);
        data = apb_rsp.prdata;                       // Access phase, stable mid-cycle
        check_apb_response();
        @(posedge clk_i);
        apb_req <= '0;
    endtask

    task automatic wait_status(input int idx, input logic level);
        logic [31:0] st;
        apb_read(`UART_STATUS_ADDR, st);
        while (st[idx] !== level) begin
            apb_read(`UART_STATUS_ADDR, st);
        end
    endtask

    task automatic configure(input uart_div_t div, input logic [31:0] ctrl);
        apb_write(`UART_CONTROL_ADDR, 32'h0);        // Both paths idle while the divider moves
        apb_write(`UART_CLK_DIV_ADDR, 32'(div));
        apb_write(`UART_CONTROL_ADDR, ctrl);
    endtask

    task automatic send_frame(input int div, input uart_byte_t data, input logic par_bit);
        logic [10:0] bits;
        bits = {1'b1, par_bit, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_i);
            inj_line <= bits[i];
            repeat (div - 1) @(posedge clk_i);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests

    task automatic test_registers();
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [31:0] ctrl;
        uart_div_t   div;
        random_div(div);
        configure(div, ctrl_word(1'b0, 1'b0, 1'b1, 1'b1));
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq("status_after_enable", 32'h1, rd);
        take_bits(16, rnd);
        apb_write(`UART_CLK_DIV_ADDR, {16'h0, rnd[15:0]});
        apb_read(`UART_CLK_DIV_ADDR, rd);
        check_eq("div_readback", {16'h0, rnd[15:0]}, rd);
        take_bits(4, rnd);
        ctrl = {28'h0, rnd[3:1], 1'b0};              // Transmit path kept in reset
        apb_write(`UART_CONTROL_ADDR, ctrl);
        apb_read(`UART_CONTROL_ADDR, rd);
        check_eq("ctrl_readback", ctrl, rd);
        apb_read(32'h0000_0014, rd);
        check_eq("undecoded_read", 32'h0, rd);
        apb_read(`UART_TX_DATA_ADDR, rd);
        check_eq("tx_data_read", 32'h0, rd);
        apb_write(`UART_TX_DATA_ADDR, 32'h0000_0055);
        repeat (50) begin
            @(negedge clk_i);
            check_eq("tx_line_in_reset", 32'h1, 32'(uart_tx));
        end
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq("busy_in_reset", 32'h0, 32'(rd[ST_BUSY]));
    endtask

    task automatic run_loopback(input string name, input logic odd, input logic even);
        logic [31:0] rnd;
        logic [31:0] rd;
        uart_div_t   div;
        uart_byte_t  b;
        random_div(div);
        loopback <= 1'b1;
        configure(div, ctrl_word(odd, even, 1'b1, 1'b1));
        for (int i = 0; i < N_BYTES; i++) begin
            take_bits(8, rnd);
            wait_status(ST_FULL, 1'b0);
            apb_write(`UART_TX_DATA_ADDR, {24'h0, rnd[7:0]});
            model_q.push_back(rnd[7:0]);
        end
        while (model_q.size() > 0) begin
            wait_status(ST_EMPTY, 1'b0);
            apb_read(`UART_RX_DATA_ADDR, rd);
            b = model_q.pop_front();
            check_eq({name, "_byte"}, 32'(b), rd);
        end
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq({name, "_parity_err"}, 32'h0, 32'(rd[ST_PERR]));
    endtask

    task automatic test_parity_error();
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [31:0] ctrl;
        uart_div_t   div;
        uart_byte_t  b;
        logic        odd;
        logic        good;
        random_div(div);
        take_bits(1, rnd);
        odd = rnd[0];
        take_bits(8, rnd);
        b = rnd[7:0];
        good = odd ? ~^b : ^b;                       // Bit that makes the count of ones right
        ctrl = ctrl_word(odd, ~odd, 1'b1, 1'b1);
        loopback <= 1'b0;
        configure(div, ctrl);
        send_frame(int'(div), b, ~good);
        wait_status(ST_EMPTY, 1'b0);
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq("parity_err_set", 32'h1, 32'(rd[ST_PERR]));
        apb_read(`UART_RX_DATA_ADDR, rd);
        check_eq("parity_err_byte", 32'(b), rd);
        apb_write(`UART_CONTROL_ADDR, ctrl & ~32'h2);
        apb_write(`UART_CONTROL_ADDR, ctrl);
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq("parity_err_cleared", 32'h0, 32'(rd[ST_PERR]));
    endtask

    task automatic test_tx_full();
        logic [31:0] rnd;
        logic [31:0] rd;
        int          start;
        int          elapsed;
        logic        in_range;
        loopback <= 1'b0;
        configure(uart_div_t'(BIG_DIV), ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        start = cycle_cnt;
        for (int i = 0; i < N_FULL; i++) begin
            take_bits(8, rnd);
            apb_write(`UART_TX_DATA_ADDR, {24'h0, rnd[7:0]});
        end
        apb_read(`UART_STATUS_ADDR, rd);
        check_eq("tx_fifo_full", 32'h1, 32'(rd[ST_FULL]));
        check_eq("tx_busy_high", 32'h1, 32'(rd[ST_BUSY]));
        wait_status(ST_BUSY, 1'b0);
        elapsed = cycle_cnt - start;
        in_range = (elapsed >= N_FULL * 10 * BIG_DIV)
                && (elapsed <= N_FULL * (10 * BIG_DIV + 1) + 40);
        check_eq("tx_busy_length", 32'h1, 32'(in_range));
    endtask

    initial begin
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        apb_req   = '0;
        inj_line  = 1'b1;
        loopback  = 1'b0;
        cycle_cnt = 0;
        lfsr_q    = 32'hdf33_1d0a;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_registers();
        run_loopback("loop_none", 1'b0, 1'b0);
        run_loopback("loop_odd", 1'b1, 1'b0);
        run_loopback("loop_even", 1'b0, 1'b1);
        test_parity_error();
        test_tx_full();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/uart_line_pkg.sv
src/uart_reg_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/apb_uart_regs.sv
src/apb_uart.sv
bench/tb_apb_uart.sv

// ==== src/apb_uart.sv ====
// APB UART top level
`timescale 1ns/1ns

module apb_uart (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  uart_reg_pkg::apb_req_t apb_i,
    output uart_reg_pkg::apb_rsp_t apb_o,
    input  logic                   uart_rx_i,
    output logic                   uart_tx_o
);
    import uart_line_pkg::*;

    byte_stream_t tx_stream;
    logic         tx_ready;
    logic         tx_full;
    logic         tx_busy;
    byte_stream_t rx_stream;
    logic         rx_ready;
    uart_div_t    clk_div;
    parity_cfg_t  parity;
    logic         tx_rstn;     // Already combined with rstn_i
    logic         rx_rstn;
    logic         parity_err;

    apb_uart_regs u_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .apb_i       (apb_i),
        .apb_o       (apb_o),
        .tx_o        (tx_stream),
        .tx_ready_i  (tx_ready),
        .tx_full_i   (tx_full),
        .tx_busy_i   (tx_busy),
        .rx_i        (rx_stream),
        .rx_ready_o  (rx_ready),
        .parity_err_i(parity_err),
        .div_o       (clk_div),
        .parity_o    (parity),
        .tx_rstn_o   (tx_rstn),
        .rx_rstn_o   (rx_rstn)
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .rstn_i    (tx_rstn),
        .div_i     (clk_div),
        .parity_i  (parity),
        .in_i      (tx_stream),
        .in_ready_o(tx_ready),
        .full_o    (tx_full),
        .busy_o    (tx_busy),
        .uart_tx_o (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i       (clk_i),
        .rstn_i      (rx_rstn),
        .div_i       (clk_div),
        .parity_i    (parity),
        .uart_rx_i   (uart_rx_i),
        .out_o       (rx_stream),
        .out_ready_i (rx_ready),
        .parity_err_o(parity_err)
    );

endmodule

// ==== src/apb_uart_regs.sv ====
// APB register block of the UART
`timescale 1ns/1ns
`include "uart_defs.svh"

module apb_uart_regs (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  uart_reg_pkg::apb_req_t      apb_i,
    output uart_reg_pkg::apb_rsp_t      apb_o,
    output uart_line_pkg::byte_stream_t tx_o,
    input  logic                        tx_ready_i,
    input  logic                        tx_full_i,
    input  logic                        tx_busy_i,
    input  uart_line_pkg::byte_stream_t rx_i,
    output logic                        rx_ready_o,
    input  logic                        parity_err_i,
    output uart_line_pkg::uart_div_t    div_o,
    output uart_line_pkg::parity_cfg_t  parity_o,
    output logic                        tx_rstn_o,
    output logic                        rx_rstn_o
);
    import uart_line_pkg::*;
    import uart_reg_pkg::*;

    logic        wr_access;
    logic        rd_access;
    uart_div_t   div_q;
    ctrl_reg_t   ctrl_q;
    logic        tx_valid_q;
    uart_byte_t  tx_data_q;
    logic        parity_err_q;
    status_reg_t status;

    assign wr_access = apb_i.psel & apb_i.penable & apb_i.pwrite;
    assign rd_access = apb_i.psel & apb_i.penable & ~apb_i.pwrite;

    assign rx_ready_o = rd_access & (apb_i.paddr == `UART_RX_DATA_ADDR);   // Read pops
    assign tx_o       = '{valid: tx_valid_q, data: tx_data_q};
    assign div_o      = div_q;
    assign parity_o   = '{parity_odd: ctrl_q.parity_odd, parity_even: ctrl_q.parity_even};
    assign tx_rstn_o  = rstn_i & ctrl_q.tx_rstn;
    assign rx_rstn_o  = rstn_i & ctrl_q.rx_rstn;

    assign status = '{rsrvd: '0, tx_busy: tx_busy_i, parity_err: parity_err_q,
                      tx_fifo_full: tx_full_i, rx_fifo_empty: ~rx_i.valid};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            div_q      <= '0;
            ctrl_q     <= '0;
            tx_valid_q <= 1'b0;
        end else begin
            if (wr_access && apb_i.paddr == `UART_CLK_DIV_ADDR) div_q <= uart_div_t'(apb_i.pwdata);
            if (wr_access && apb_i.paddr == `UART_CONTROL_ADDR) ctrl_q <= apb_i.pwdata;
            if (wr_access && apb_i.paddr == `UART_TX_DATA_ADDR) tx_valid_q <= 1'b1;
            else if (tx_ready_i) tx_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_access && apb_i.paddr == `UART_TX_DATA_ADDR) begin
            tx_data_q <= uart_byte_t'(apb_i.pwdata);     // Overwrites a byte still pending
        end
    end

    // Sticky until the receive path goes through reset
    always_ff @(posedge clk_i) begin
        if (!rx_rstn_o) parity_err_q <= 1'b0;
        else if (parity_err_i) parity_err_q <= 1'b1;
    end

    always_comb begin
        apb_o.prdata  = '0;
        apb_o.pready  = 1'b1;
        apb_o.pslverr = 1'b0;
        if (rd_access) begin
            case (apb_i.paddr)
                `UART_CLK_DIV_ADDR: apb_o.prdata = apb_data_t'(div_q);
                `UART_CONTROL_ADDR: apb_o.prdata = ctrl_q;
                `UART_RX_DATA_ADDR: apb_o.prdata = rx_i.valid ? apb_data_t'(rx_i.data) : '0;
                `UART_STATUS_ADDR:  apb_o.prdata = status;
                default:            apb_o.prdata = '0;               // TX data is write only
            endcase
        end
    end

    a_pready : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (apb_i.psel && apb_i.penable) |-> apb_o.pready);

endmodule

// ==== src/uart_defs.svh ====
// UART widths and register map
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_DATA_W       8
`define UART_DIV_W        16
`define UART_FIFO_DEPTH   16

`define APB_ADDR_W        32
`define APB_DATA_W        32

// Byte addresses of the word registers
`define UART_CLK_DIV_ADDR 32'h0000_0000
`define UART_CONTROL_ADDR 32'h0000_0004
`define UART_TX_DATA_ADDR 32'h0000_0008
`define UART_RX_DATA_ADDR 32'h0000_000C
`define UART_STATUS_ADDR  32'h0000_0010

`endif

// ==== src/uart_fifo.sv ====
// Synchronous byte FIFO
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  uart_line_pkg::byte_stream_t in_i,
    output logic                        in_ready_o,
    output uart_line_pkg::byte_stream_t out_o,
    input  logic                        out_ready_i,
    output logic                        full_o
);
    import uart_line_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o     = (count_q == CNT_W'(DEPTH));
    assign in_ready_o = ~full_o;
    assign out_o      = '{valid: (count_q != '0), data: mem[rd_ptr_q]};
    assign push       = in_i.valid & in_ready_o;
    assign pop        = out_o.valid & out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    a_count_bound : assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_q <= CNT_W'(DEPTH));
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (count_q == '0) |=> (count_q <= CNT_W'(1)));

endmodule

// ==== src/uart_line_pkg.sv ====
// UART serial-side types
`include "uart_defs.svh"

package uart_line_pkg;

    typedef logic [`UART_DATA_W-1:0] uart_byte_t;
    typedef logic [`UART_DIV_W-1:0]  uart_div_t;   // Clock cycles per bit

    typedef struct packed {
        logic parity_odd;                          // Wins over even when both are set
        logic parity_even;
    } parity_cfg_t;

    // Producer side of a byte stream, ready travels back on its own wire
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } byte_stream_t;

endpackage

// ==== src/uart_reg_pkg.sv ====
// UART register-side types
`include "uart_defs.svh"

package uart_reg_pkg;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`APB_DATA_W-5:0] rsrvd;
        logic                   parity_even;
        logic                   parity_odd;
        logic                   rx_rstn;
        logic                   tx_rstn;       // Bit 0
    } ctrl_reg_t;

    typedef struct packed {
        logic [`APB_DATA_W-5:0] rsrvd;
        logic                   tx_busy;
        logic                   parity_err;
        logic                   tx_fifo_full;
        logic                   rx_fifo_empty; // Bit 0
    } status_reg_t;

endpackage

// ==== src/uart_rx.sv ====
// UART receive path
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_rx (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  uart_line_pkg::uart_div_t    div_i,
    input  uart_line_pkg::parity_cfg_t  parity_i,
    input  logic                        uart_rx_i,
    output uart_line_pkg::byte_stream_t out_o,
    input  logic                        out_ready_i,
    output logic                        parity_err_o
);
    import uart_line_pkg::*;

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_e;

    rx_state_e    state_q;
    logic [1:0]   sync_q;
    logic         rx_prev_q;
    logic         rx_s;
    logic         par_en;
    logic         bit_end;
    logic         mid_start;
    uart_div_t    baud_cnt_q;
    logic [2:0]   bit_cnt_q;
    uart_byte_t   shift_q;
    logic         par_bad_q;
    logic         push_q;
    logic         parity_err_q;
    byte_stream_t fifo_in;

    uart_fifo u_rx_fifo (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .in_i       (fifo_in),
        .in_ready_o (),                                        // Line cannot stall, full drops
        .out_o      (out_o),
        .out_ready_i(out_ready_i),
        .full_o     ()
    );

    assign rx_s         = sync_q[1];
    assign par_en       = parity_i.parity_odd | parity_i.parity_even;
    assign bit_end      = (baud_cnt_q == div_i - 1'b1);
    assign mid_start    = (baud_cnt_q == (div_i >> 1));
    assign fifo_in      = '{valid: push_q, data: shift_q};     // Shift register holds until next frame
    assign parity_err_o = parity_err_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], uart_rx_i};
            rx_prev_q <= rx_s;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mid-bit sampler

    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_end) begin
            shift_q <= {rx_s, shift_q[`UART_DATA_W-1:1]};        // LSB arrives first
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= IDLE;
            baud_cnt_q   <= '0;
            bit_cnt_q    <= '0;
            par_bad_q    <= 1'b0;
            push_q       <= 1'b0;
            parity_err_q <= 1'b0;
        end else begin
            push_q       <= 1'b0;
            parity_err_q <= 1'b0;
            if (state_q == IDLE || bit_end || (state_q == START && mid_start)) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            case (state_q)
                IDLE: if (rx_prev_q && !rx_s) begin
                    par_bad_q <= 1'b0;
                    state_q   <= START;
                end
                START: if (mid_start) begin
                    bit_cnt_q <= '0;
                    state_q   <= rx_s ? IDLE : DATA;         // Glitch, not a start bit
                end
                DATA: if (bit_end) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == 3'(`UART_DATA_W - 1)) state_q <= par_en ? PARITY : STOP;
                end
                PARITY: if (bit_end) begin
                    par_bad_q <= rx_s ^ (^shift_q) ^ parity_i.parity_odd;
                    state_q   <= STOP;
                end
                STOP: if (bit_end) begin
                    push_q       <= 1'b1;
                    parity_err_q <= par_en & par_bad_q;
                    state_q      <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/uart_tx.sv ====
// UART transmit path
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_tx (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  uart_line_pkg::uart_div_t    div_i,
    input  uart_line_pkg::parity_cfg_t  parity_i,
    input  uart_line_pkg::byte_stream_t in_i,
    output logic                        in_ready_o,
    output logic                        full_o,
    output logic                        busy_o,
    output logic                        uart_tx_o
);
    import uart_line_pkg::*;

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} tx_state_e;

    tx_state_e    state_q;
    byte_stream_t fifo_out;
    logic         fifo_rd_ready;
    logic         load;
    logic         bit_end;
    uart_div_t    baud_cnt_q;
    logic [2:0]   bit_cnt_q;
    uart_byte_t   shift_q;
    logic         par_bit_q;
    logic         tx_q;

    uart_fifo u_tx_fifo (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .in_i       (in_i),
        .in_ready_o (in_ready_o),
        .out_o      (fifo_out),
        .out_ready_i(fifo_rd_ready),
        .full_o     (full_o)
    );

    assign fifo_rd_ready = (state_q == IDLE);                  // Pop as the frame starts
    assign load          = fifo_rd_ready & fifo_out.valid;
    assign bit_end       = (baud_cnt_q == div_i - 1'b1);
    assign busy_o        = fifo_out.valid | (state_q != IDLE);
    assign uart_tx_o     = tx_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame serializer

    always_ff @(posedge clk_i) begin
        if (load) begin
            shift_q   <= fifo_out.data;
            par_bit_q <= (^fifo_out.data) ^ parity_i.parity_odd;
        end else if (state_q == DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_q       <= 1'b1;
        end else begin
            baud_cnt_q <= (state_q == IDLE || bit_end) ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                IDLE: if (load) begin
                    tx_q    <= 1'b0;
                    state_q <= START;
                end
                START: if (bit_end) begin
                    tx_q      <= shift_q[0];
                    bit_cnt_q <= '0;
                    state_q   <= DATA;
                end
                DATA: if (bit_end) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == 3'(`UART_DATA_W - 1)) begin
                        tx_q    <= (parity_i.parity_odd | parity_i.parity_even) ? par_bit_q : 1'b1;
                        state_q <= (parity_i.parity_odd | parity_i.parity_even) ? PARITY : STOP;
                    end else begin
                        tx_q <= shift_q[1];
                    end
                end
                PARITY: if (bit_end) begin
                    tx_q    <= 1'b1;
                    state_q <= STOP;
                end
                STOP: if (bit_end) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    a_idle_high : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == IDLE) |-> uart_tx_o);

endmodule
